// File: riscv_dm_bus_front.sv
`timescale 1ns/1ns
`include "riscv_dm_settings.svh"

module riscv_dm_bus_front (
  input  logic                            i_riscv_dm_rst,
  input  logic                            i_riscv_dm_clk_n,
  input  logic                            i_wb_cyc,
  input  logic                            i_wb_stb,
  input  logic                            i_wb_we,
  input  logic [`RISCV_DM_ADDR_W-1:0]     i_wb_adr,
  input  riscv_dm_pkg::dword_t            i_wb_dat,
  input  riscv_dm_pkg::mem_size_e         i_dm_size,
  input  logic                            i_dm_unsigned,
  output logic                            o_wb_ack,
  output logic                            o_wb_err,
  output riscv_dm_pkg::lane_mask_t        o_lane_we,
  output riscv_dm_pkg::dword_t            o_lane_wdata,
  output logic [`RISCV_DM_WORDS_LOG2-1:0] o_word_idx,
  output logic [`RISCV_DM_OFS_W-1:0]      o_ld_offset,
  output riscv_dm_pkg::mem_size_e         o_ld_size,
  output logic                            o_ld_unsigned
);

  // Lowest address bit above the memory window.
  localparam int WIN_TOP = `RISCV_DM_OFS_W + `RISCV_DM_WORDS_LOG2;

  logic [`RISCV_DM_OFS_W-1:0]   offset;
  logic [3:0]                   nbytes;
  logic                         in_range;
  logic                         fits;
  logic                         request;
  logic                         accept;
  riscv_dm_pkg::lane_mask_t     base_mask;
  logic [2*$bits(riscv_dm_pkg::dword_t)-1:0] wdata_dbl;

  assign offset     = i_wb_adr[`RISCV_DM_OFS_W-1:0];          // Byte lane of the first byte.
  assign o_word_idx = i_wb_adr[`RISCV_DM_OFS_W +: `RISCV_DM_WORDS_LOG2];

  // Every address bit above the window must be zero.
  assign in_range = (i_wb_adr[`RISCV_DM_ADDR_W-1:WIN_TOP] == '0);

  // The access must end inside the addressed doubleword.
  assign nbytes = riscv_dm_pkg::size_bytes(i_dm_size);
  assign fits   = (({1'b0, offset} + nbytes) <= 4'd8);

  // A new cycle starts only while no answer is being driven.
  assign request = i_wb_cyc & i_wb_stb & ~o_wb_ack & ~o_wb_err;
  assign accept  = request & in_range & fits;

  always_comb
  begin
    case (i_dm_size)
      riscv_dm_pkg::mem_byte:
        base_mask = 8'h01;
      riscv_dm_pkg::mem_half:
        base_mask = 8'h03;
      riscv_dm_pkg::mem_word:
        base_mask = 8'h0f;
      default:
        base_mask = 8'hff;
    endcase
  end

  // The mask never wraps because crossing accesses are refused.
  assign o_lane_we = (accept & i_wb_we) ? riscv_dm_pkg::lane_mask_t'(base_mask << offset) : '0;

  // Rotate left by the offset so data byte 0 lands in the addressed lane.
  assign wdata_dbl    = {i_wb_dat, i_wb_dat} << {offset, 3'b000};
  assign o_lane_wdata = wdata_dbl[$bits(wdata_dbl)-1 -: $bits(riscv_dm_pkg::dword_t)];

  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      o_wb_ack <= 1'b0;
      o_wb_err <= 1'b0;
    end
    else
    begin
      o_wb_ack <= accept;                        // Good cycles are answered next period.
      o_wb_err <= request & ~accept;             // Refused cycles get an error instead.
    end
  end

  // Load context for the extractor during the answer cycle.
  always_ff @(posedge i_riscv_dm_rst)
  begin
    if (request)
    begin
      o_ld_offset   <= offset;
      o_ld_size     <= i_dm_size;
      o_ld_unsigned <= i_dm_unsigned;
    end
  end

endmodule

// File: riscv_dm_byte_bank.sv
`timescale 1ns/1ns
`include "riscv_dm_settings.svh"

module riscv_dm_byte_bank #(
  parameter int IDX_W = `RISCV_DM_WORDS_LOG2      // Index width, so 2**IDX_W entries.
) (
  input  logic                        i_riscv_dm_rst,
  input  logic                        i_we,
  input  logic [IDX_W-1:0]            i_idx,
  input  logic [`RISCV_DM_LANE_W-1:0] i_wdata,
  output logic [`RISCV_DM_LANE_W-1:0] o_rdata
);

  // One byte of every doubleword in the window.
  logic [`RISCV_DM_LANE_W-1:0] mem [0:(2**IDX_W)-1];

  // Write port for the lane.
  always_ff @(posedge i_riscv_dm_rst)
  begin
    if (i_we)
    begin
      mem[i_idx] <= i_wdata;                     // Store only when this lane is enabled.
    end
  end

  // Registered read of the same entry.
  // A write on the same edge is seen one cycle later.
  always_ff @(posedge i_riscv_dm_rst)
  begin
    o_rdata <= mem[i_idx];                       // Old contents on a same-edge write.
  end

endmodule

// File: riscv_dm_checker.sv
`timescale 1ns/1ns

module riscv_dm_checker (
  input  logic i_riscv_dm_rst,
  input  logic i_riscv_dm_clk_n,
  input  logic i_wb_cyc,
  input  logic i_wb_stb,
  input  logic i_wb_ack,
  input  logic i_wb_err
);

  int unsigned excl_fails = 0;                   // Ack and err seen together.
  int unsigned width_fails = 0;                  // Answer held longer than one cycle.
  int unsigned cause_fails = 0;                  // Answer without a preceding strobe.
  int unsigned fail_total;

  assign fail_total = excl_fails + width_fails + cause_fails;

  no_double_answer: assert property (@(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    !(i_wb_ack && i_wb_err))
  else
  begin
    $error("Ack and err are high in the same cycle.");
    excl_fails++;
  end

  single_cycle_answer: assert property (@(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    (i_wb_ack || i_wb_err) |=> !(i_wb_ack || i_wb_err))
  else
  begin
    $error("Ack or err stayed high for more than one cycle.");
    width_fails++;
  end

  // The strobe of the accepted cycle was sampled one edge earlier.
  answer_after_stb: assert property (@(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    (i_wb_ack || i_wb_err) |-> $past(i_wb_cyc && i_wb_stb))
  else
  begin
    $error("Ack or err was raised without a strobe in the cycle before.");
    cause_fails++;
  end

endmodule

bind riscv_dm_top riscv_dm_checker chk0 (
  .i_riscv_dm_rst   (i_riscv_dm_rst),
  .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
  .i_wb_cyc         (i_wb_cyc),
  .i_wb_stb         (i_wb_stb),
  .i_wb_ack         (o_wb_ack),
  .i_wb_err         (o_wb_err)
);

// File: riscv_dm_load_extract.sv
`timescale 1ns/1ns
`include "riscv_dm_settings.svh"

module riscv_dm_load_extract (
  input  riscv_dm_pkg::dword_t        i_lane_rdata,
  input  logic [`RISCV_DM_OFS_W-1:0]  i_offset,
  input  riscv_dm_pkg::mem_size_e     i_size,
  input  logic                        i_unsigned,
  output riscv_dm_pkg::dword_t        o_rdata
);

  logic [2*$bits(riscv_dm_pkg::dword_t)-1:0] rdata_dbl;
  riscv_dm_pkg::dword_t                      aligned;
  logic                                      sign_bit;

  // Rotate right by the offset so the addressed byte becomes byte 0.
  assign rdata_dbl = {i_lane_rdata, i_lane_rdata} >> {i_offset, 3'b000};
  assign aligned   = rdata_dbl[$bits(riscv_dm_pkg::dword_t)-1:0];

  // Top bit of the kept part selects the fill for signed loads.
  always_comb
  begin
    case (i_size)
      riscv_dm_pkg::mem_byte:
        sign_bit = aligned[7];
      riscv_dm_pkg::mem_half:
        sign_bit = aligned[15];
      riscv_dm_pkg::mem_word:
        sign_bit = aligned[31];
      default:
        sign_bit = aligned[63];
    endcase
  end

  // Keep the access size and fill the rest.
  always_comb
  begin
    case (i_size)
      riscv_dm_pkg::mem_byte:
      begin
        o_rdata = {{56{sign_bit & ~i_unsigned}}, aligned[7:0]};    // LB or LBU.
      end
      riscv_dm_pkg::mem_half:
      begin
        o_rdata = {{48{sign_bit & ~i_unsigned}}, aligned[15:0]};   // LH or LHU.
      end
      riscv_dm_pkg::mem_word:
      begin
        o_rdata = {{32{sign_bit & ~i_unsigned}}, aligned[31:0]};   // LW or LWU.
      end
      default:
      begin
        o_rdata = aligned;                       // LD has nothing to extend.
      end
    endcase
  end

endmodule

// File: riscv_dm_pkg.sv
`include "riscv_dm_settings.svh"

package riscv_dm_pkg;

  // Access size of a load or store.
  typedef enum logic [1:0]
  {
    mem_byte   = 2'd0,                        // One byte.
    mem_half   = 2'd1,                        // Two bytes.
    mem_word   = 2'd2,                        // Four bytes.
    mem_double = 2'd3                         // Eight bytes.
  } mem_size_e;

  typedef logic [`RISCV_DM_LANES-1:0] lane_mask_t;   // One write enable per byte lane.

  typedef logic [`RISCV_DM_LANES*`RISCV_DM_LANE_W-1:0] dword_t;  // Full data word.

  // Number of bytes moved by an access of the given size.
  function automatic logic [3:0] size_bytes(mem_size_e size);
    case (size)
      mem_byte:
        size_bytes = 4'd1;
      mem_half:
        size_bytes = 4'd2;
      mem_word:
        size_bytes = 4'd4;
      default:
        size_bytes = 4'd8;
    endcase
  endfunction

endpackage

// File: riscv_dm_settings.svh
`ifndef RISCV_DM_SETTINGS_SVH
`define RISCV_DM_SETTINGS_SVH

// Width of the Wishbone byte address.
`define RISCV_DM_ADDR_W 64

// Log2 of the number of doublewords kept in the memory window.
// With the default of 10 the window holds 8 KiB.
`define RISCV_DM_WORDS_LOG2 10

// Number of byte lanes, one storage bank per lane.
`define RISCV_DM_LANES 8

// Width of the byte offset inside one doubleword.
`define RISCV_DM_OFS_W $clog2(`RISCV_DM_LANES)

// Width of one lane in bits.
`define RISCV_DM_LANE_W 8

`endif

// File: riscv_dm_stimulus.txt
# name we size unsigned address(hex) data(hex) expected(hex) expect_err
# we 1 is a store, size 0..3 is byte/half/word/double, expected is checked on loads only
st_d_000        1 3 0 0000             5555aaaa5555aaaa 0                0
st_d_100        1 3 0 0100             0123456789abcdef 0                0
ld_d_100        0 3 0 0100             0                0123456789abcdef 0
st_b_103        1 0 0 0103             77777777777777a5 0                0
st_h_106        1 1 0 0106             0000000099995a5a 0                0
ld_d_merge1     0 3 0 0100             0                5a5a4567a5abcdef 0
st_w_104        1 2 0 0104             cccccccc11223344 0                0
ld_d_merge2     0 3 0 0100             0                11223344a5abcdef 0
st_b_100        1 0 0 0100             000000000000003c 0                0
ld_d_merge3     0 3 0 0100             0                11223344a5abcd3c 0
st_d_200        1 3 0 0200             f0e1d2c3b4a59687 0                0
lb_200          0 0 0 0200             0                ffffffffffffff87 0
lbu_200         0 0 1 0200             0                0000000000000087 0
lb_205          0 0 0 0205             0                ffffffffffffffd2 0
lbu_207         0 0 1 0207             0                00000000000000f0 0
lh_202          0 1 0 0202             0                ffffffffffffb4a5 0
lhu_202         0 1 1 0202             0                000000000000b4a5 0
lh_206          0 1 0 0206             0                fffffffffffff0e1 0
lw_204          0 2 0 0204             0                fffffffff0e1d2c3 0
lwu_204         0 2 1 0204             0                00000000f0e1d2c3 0
lw_200          0 2 0 0200             0                ffffffffb4a59687 0
st_d_300        1 3 0 0300             000000000000417f 0                0
lb_300_pos      0 0 0 0300             0                000000000000007f 0
lh_300_pos      0 1 0 0300             0                000000000000417f 0
st_d_1ff8       1 3 0 1ff8             deadbeefcafef00d 0                0
ld_d_1ff8       0 3 0 1ff8             0                deadbeefcafef00d 0
st_h_207_cross  1 1 0 0207             000000000000ffff 0                1
ld_w_206_cross  0 2 0 0206             0                0                1
st_d_201_cross  1 3 0 0201             ffffffffffffffff 0                1
st_d_2000_oor   1 3 0 2000             ffffffffffffffff 0                1
st_d_high_oor   1 3 0 8000000000000100 ffffffffffffffff 0                1
ld_d_2000_oor   0 3 0 2000             0                0                1
ld_d_000_after  0 3 0 0000             0                5555aaaa5555aaaa 0
ld_d_100_after  0 3 0 0100             0                11223344a5abcd3c 0
ld_d_200_after  0 3 0 0200             0                f0e1d2c3b4a59687 0

// File: riscv_dm_tb.sv
`timescale 1ns/1ns
`include "riscv_dm_settings.svh"

module riscv_dm_tb;

  localparam int MAX_TESTS = 64;
  localparam int ANSWER_LIMIT = 4;               // Edges to wait for ack or err.
  localparam int WATCHDOG_MARGIN = 20;

  logic                         riscv_dm_rst = 1'b0;   // DUT clock.
  logic                         riscv_dm_clk_n;        // DUT reset, active low.
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [`RISCV_DM_ADDR_W-1:0]  wb_adr;
  riscv_dm_pkg::dword_t         wb_dat_w;
  riscv_dm_pkg::dword_t         wb_dat_r;
  logic                         wb_ack;
  logic                         wb_err;
  riscv_dm_pkg::mem_size_e      dm_size;
  logic                         dm_unsigned;

  // One entry per line of the stimulus file.
  string                        t_name [MAX_TESTS];
  logic                         t_we [MAX_TESTS];
  riscv_dm_pkg::mem_size_e      t_size [MAX_TESTS];
  logic                         t_uns [MAX_TESTS];
  logic [`RISCV_DM_ADDR_W-1:0]  t_adr [MAX_TESTS];
  riscv_dm_pkg::dword_t         t_dat [MAX_TESTS];
  riscv_dm_pkg::dword_t         t_exp [MAX_TESTS];
  logic                         t_err [MAX_TESTS];

  int                           num_tests = 0;
  int                           pass_count = 0;
  int                           fail_count = 0;

  riscv_dm_top dut0 (
    .i_riscv_dm_rst   (riscv_dm_rst),
    .i_riscv_dm_clk_n (riscv_dm_clk_n),
    .i_wb_cyc         (wb_cyc),
    .i_wb_stb         (wb_stb),
    .i_wb_we          (wb_we),
    .i_wb_adr         (wb_adr),
    .i_wb_dat         (wb_dat_w),
    .o_wb_dat         (wb_dat_r),
    .o_wb_ack         (wb_ack),
    .o_wb_err         (wb_err),
    .i_dm_size        (dm_size),
    .i_dm_unsigned    (dm_unsigned)
  );

  always #4 riscv_dm_rst = ~riscv_dm_rst;        // 8 ns period.

  // Lines starting with # are comments, others hold eight fields.
  task automatic load_stimulus();
    int                    fd;
    int                    we_i;
    int                    size_i;
    int                    uns_i;
    int                    err_i;
    string                 line;
    string                 name;
    logic [63:0]           adr;
    logic [63:0]           dat;
    logic [63:0]           exp;
    fd = $fopen("riscv_dm_stimulus.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd) && num_tests < MAX_TESTS)
      begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#")
        begin
          if ($sscanf(line, "%s %d %d %d %h %h %h %d", name, we_i, size_i, uns_i,
                      adr, dat, exp, err_i) == 8)
          begin
            t_name[num_tests] = name;
            t_we[num_tests]   = (we_i != 0);
            t_size[num_tests] = riscv_dm_pkg::mem_size_e'(size_i[1:0]);
            t_uns[num_tests]  = (uns_i != 0);
            t_adr[num_tests]  = adr;
            t_dat[num_tests]  = dat;
            t_exp[num_tests]  = exp;
            t_err[num_tests]  = (err_i != 0);
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_test(input string name, input logic ok);
    if (ok)
    begin
      pass_count++;
      $display("test %0s: pass", name);
    end
    else
    begin
      fail_count++;
      $display("test %0s: fail", name);
    end
  endtask

  // Neither answer may appear before the first access.
  task automatic check_idle_after_reset();
    logic ok;
    ok = 1'b1;
    repeat (3)
    begin
      @(negedge riscv_dm_rst);
      assert (!wb_ack && !wb_err)
      else
      begin
        $display("An answer was raised after reset before any access was made.");
        ok = 1'b0;
      end
    end
    report_test("reset_idle", ok);
  endtask

  task automatic run_access(input int i);
    int                    cycles;
    logic                  got_ack;
    logic                  got_err;
    logic                  repeated;
    logic                  ok;
    riscv_dm_pkg::dword_t  got_dat;
    @(negedge riscv_dm_rst);
    wb_cyc      = 1'b1;
    wb_stb      = 1'b1;
    wb_we       = t_we[i];
    wb_adr      = t_adr[i];
    wb_dat_w    = t_dat[i];
    dm_size     = t_size[i];
    dm_unsigned = t_uns[i];
    cycles   = 0;
    got_ack  = 1'b0;
    got_err  = 1'b0;
    repeated = 1'b0;
    got_dat  = '0;
    while (!got_ack && !got_err && cycles < ANSWER_LIMIT)
    begin
      @(negedge riscv_dm_rst);                   // Outputs are settled mid-cycle.
      cycles++;
      got_ack = wb_ack;
      got_err = wb_err;
      got_dat = wb_dat_r;
    end
    if (got_ack || got_err)
    begin
      // The strobe stays up through the edge that ends the answer cycle.
      @(negedge riscv_dm_rst);
      repeated = wb_ack || wb_err;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    ok = 1'b1;
    assert (got_ack || got_err)
    else
    begin
      $display("%0s: no ack or err within %0d cycles.", t_name[i], ANSWER_LIMIT);
      ok = 1'b0;
    end
    if (got_ack || got_err)
    begin
      assert (cycles == 1)
      else
      begin
        $display("%0s: answered after %0d cycles instead of one.", t_name[i], cycles);
        ok = 1'b0;
      end
      assert (!repeated)
      else
      begin
        $display("%0s: the answer was repeated while the strobe was still held.", t_name[i]);
        ok = 1'b0;
      end
      assert (got_err == t_err[i])
      else
      begin
        if (t_err[i])
          $display("%0s: expected an error answer but got an ack.", t_name[i]);
        else
          $display("%0s: got an error answer where an ack was expected.", t_name[i]);
        ok = 1'b0;
      end
      if (got_ack && !t_err[i] && !t_we[i])
      begin
        assert (got_dat === t_exp[i])
        else
        begin
          $display("MISMATCH %0s: expected %h, actual %h", t_name[i], t_exp[i], got_dat);
          ok = 1'b0;
        end
      end
    end
    report_test(t_name[i], ok);
  endtask

  initial
  begin
    wait (num_tests > 0);
    repeat (num_tests * 10 + WATCHDOG_MARGIN) @(posedge riscv_dm_rst);
    $display("Watchdog expired before all tests finished.");
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    riscv_dm_clk_n = 1'b0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_w       = '0;
    dm_size        = riscv_dm_pkg::mem_byte;
    dm_unsigned    = 1'b0;
    load_stimulus();
    if (num_tests == 0)
    begin
      $display("No test could be read from riscv_dm_stimulus.txt.");
      $display("TEST FAILED");
      $finish;
    end
    else
    begin
      repeat (2) @(posedge riscv_dm_rst);
      @(negedge riscv_dm_rst);
      riscv_dm_clk_n = 1'b1;
      check_idle_after_reset();
      for (int i = 0; i < num_tests; i++)
      begin
        run_access(i);
      end
      @(negedge riscv_dm_rst);
      $display("Tests run: %0d, passed: %0d, failed: %0d, protocol assertion failures: %0d",
               pass_count + fail_count, pass_count, fail_count, dut0.chk0.fail_total);
      if (fail_count == 0 && dut0.chk0.fail_total == 0)
        $display("TEST PASSED");
      else
        $display("TEST FAILED");
      $finish;
    end
  end

endmodule

// File: riscv_dm_top.sv
`timescale 1ns/1ns
`include "riscv_dm_settings.svh"

module riscv_dm_top (
  input  logic                        i_riscv_dm_rst,
  input  logic                        i_riscv_dm_clk_n,
  input  logic                        i_wb_cyc,
  input  logic                        i_wb_stb,
  input  logic                        i_wb_we,
  input  logic [`RISCV_DM_ADDR_W-1:0] i_wb_adr,
  input  riscv_dm_pkg::dword_t        i_wb_dat,
  output riscv_dm_pkg::dword_t        o_wb_dat,
  output logic                        o_wb_ack,
  output logic                        o_wb_err,
  input  riscv_dm_pkg::mem_size_e     i_dm_size,
  input  logic                        i_dm_unsigned
);

  riscv_dm_pkg::lane_mask_t           lane_we;
  riscv_dm_pkg::dword_t               lane_wdata;
  riscv_dm_pkg::dword_t               lane_rdata;
  logic [`RISCV_DM_WORDS_LOG2-1:0]    word_idx;
  logic [`RISCV_DM_OFS_W-1:0]         ld_offset;
  riscv_dm_pkg::mem_size_e            ld_size;
  logic                               ld_unsigned;

  riscv_dm_bus_front front0 (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .i_wb_cyc         (i_wb_cyc),
    .i_wb_stb         (i_wb_stb),
    .i_wb_we          (i_wb_we),
    .i_wb_adr         (i_wb_adr),
    .i_wb_dat         (i_wb_dat),
    .i_dm_size        (i_dm_size),
    .i_dm_unsigned    (i_dm_unsigned),
    .o_wb_ack         (o_wb_ack),
    .o_wb_err         (o_wb_err),
    .o_lane_we        (lane_we),
    .o_lane_wdata     (lane_wdata),
    .o_word_idx       (word_idx),
    .o_ld_offset      (ld_offset),
    .o_ld_size        (ld_size),
    .o_ld_unsigned    (ld_unsigned)
  );

  // One bank per byte lane, all sharing the doubleword index.
  genvar g;
  generate
    for (g = 0; g < `RISCV_DM_LANES; g = g + 1)
    begin : lane_g
      riscv_dm_byte_bank #(
        .IDX_W (`RISCV_DM_WORDS_LOG2)
      ) bank0 (
        .i_riscv_dm_rst (i_riscv_dm_rst),
        .i_we           (lane_we[g]),
        .i_idx          (word_idx),
        .i_wdata        (lane_wdata[g*`RISCV_DM_LANE_W +: `RISCV_DM_LANE_W]),
        .o_rdata        (lane_rdata[g*`RISCV_DM_LANE_W +: `RISCV_DM_LANE_W])
      );
    end
  endgenerate

  // Combinational, so load data is ready within the ack cycle.
  riscv_dm_load_extract extract0 (
    .i_lane_rdata (lane_rdata),
    .i_offset     (ld_offset),
    .i_size       (ld_size),
    .i_unsigned   (ld_unsigned),
    .o_rdata      (o_wb_dat)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the data memory testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module riscv_dm_tb -Mdir obj_dir -o riscv_dm_sim -f sim.f \
  || { echo "Verilator build failed."; exit 1; }
./obj_dir/riscv_dm_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "Simulation passed." && exit 0 \
  || { echo "Simulation failed."; exit 1; }

// File: sim.f
+incdir+.
riscv_dm_pkg.sv
riscv_dm_byte_bank.sv
riscv_dm_load_extract.sv
riscv_dm_bus_front.sv
riscv_dm_top.sv
riscv_dm_checker.sv
riscv_dm_tb.sv
